/* hdl/uartPkg.sv */
package uartPkg;

	typedef logic [7:0] charT;
	typedef logic [7:0] statusT; // bit 7 on/off, 6..0 value
	typedef logic [1:0] lightT;
	typedef logic [4:0] indexT;

	localparam int STATUS_LEN = 9;
	localparam int LIGHT_LEN = 7;

	localparam charT ASCII_ZERO = 8'h30;
	localparam charT ASCII_ONE = 8'h31;
	localparam charT ASCII_CR = 8'h0D;
	localparam charT ASCII_SPACE = 8'h20;
	localparam charT ASCII_DOT = 8'h2E;
	localparam charT ASCII_COLON = 8'h3A;
	localparam charT ASCII_S = 8'h73; // lower case s

	typedef struct packed {
		charT code;
		logic frameErr;
	} rxCharT;

	typedef struct packed {
		indexT index;
		charT data;
	} recvReportT;

	// element 0 goes out first
	typedef charT [0:STATUS_LEN-1] statusLineT;
	typedef charT [0:LIGHT_LEN-1] lightNameT;

	typedef enum logic [1:0] {seqIdle, seqStatus, seqLight, seqDrain} seqStateE;
	typedef enum logic [1:0] {rxIdle, rxStart, rxData, rxStop} rxStateE;

	localparam lightNameT [0:3] LIGHT_NAMES = {
		{"Off", ASCII_SPACE, ASCII_SPACE, ASCII_SPACE, ASCII_CR},
		{"White", ASCII_SPACE, ASCII_CR},
		{"Sun", ASCII_SPACE, ASCII_SPACE, ASCII_SPACE, ASCII_CR},
		{"Yellow", ASCII_CR}
	};

endpackage

/* hdl/uartRx.sv */
`timescale 1ns/1ps

module uartRx #(
	parameter int ovsRate = 16
) (
	input logic Uart_CLK,
	input logic Sys_RST,
	input logic serialRx,
	output uartPkg::rxCharT rxChar,
	output logic rxValid
);
	import uartPkg::*;

	localparam int cntWidth = $clog2(ovsRate);

	logic [2:0] rxSync; // [1] is the synchronized line, [2] its last value
	logic [cntWidth-1:0] ovsCnt;
	logic [2:0] bitCnt;
	charT shiftReg;
	rxStateE rxState;

	always_ff @(posedge Uart_CLK or negedge Sys_RST) begin
		if (!Sys_RST) begin
			rxSync <= '1;
			ovsCnt <= '0;
			bitCnt <= '0;
			shiftReg <= '0;
			rxState <= rxIdle;
			rxChar <= '0;
			rxValid <= 1'b0;
		end
		else begin
			rxSync <= {rxSync[1:0], serialRx};
			rxValid <= 1'b0;
			case (rxState)
				rxIdle: begin
					ovsCnt <= '0;
					if (rxSync[2] && !rxSync[1])
						rxState <= rxStart; // falling start edge
				end
				rxStart: begin
					if (ovsCnt == cntWidth'(ovsRate / 2 - 1)) begin
						ovsCnt <= '0;
						bitCnt <= '0;
						// glitch if the line is back high at mid start bit
						rxState <= rxSync[1] ? rxIdle : rxData;
					end
					else
						ovsCnt <= ovsCnt + 1'b1;
				end
				rxData: begin
					if (ovsCnt == cntWidth'(ovsRate - 1)) begin
						ovsCnt <= '0;
						shiftReg <= {rxSync[1], shiftReg[7:1]}; // lsb first
						bitCnt <= bitCnt + 1'b1;
						if (bitCnt == 3'd7)
							rxState <= rxStop;
					end
					else
						ovsCnt <= ovsCnt + 1'b1;
				end
				rxStop: begin
					if (ovsCnt == cntWidth'(ovsRate - 1)) begin
						ovsCnt <= '0;
						rxChar.code <= shiftReg;
						rxChar.frameErr <= !rxSync[1];
						rxValid <= 1'b1;
						rxState <= rxIdle;
					end
					else
						ovsCnt <= ovsCnt + 1'b1;
				end
				default: rxState <= rxIdle;
			endcase
		end
	end

endmodule

/* hdl/uartTx.sv */
`timescale 1ns/1ps

module uartTx #(
	parameter int ovsRate = 16
) (
	input logic Uart_CLK,
	input logic Sys_RST,
	input uartPkg::charT txChar,
	input logic txWrite,
	output logic txBusy,
	output logic serialTx
);
	import uartPkg::*;

	localparam int cntWidth = $clog2(ovsRate);

	logic [9:0] frame; // stop, data, start
	logic [cntWidth-1:0] ovsCnt;
	logic [3:0] bitCnt;

	always_ff @(posedge Uart_CLK or negedge Sys_RST) begin
		if (!Sys_RST) begin
			frame <= '1; // line idles high
			ovsCnt <= '0;
			bitCnt <= '0;
			txBusy <= 1'b0;
		end
		else if (txWrite && !txBusy) begin
			frame <= {1'b1, charT'(txChar), 1'b0};
			ovsCnt <= '0;
			bitCnt <= '0;
			txBusy <= 1'b1;
		end
		else if (txBusy) begin
			if (ovsCnt == cntWidth'(ovsRate - 1)) begin
				ovsCnt <= '0;
				frame <= {1'b1, frame[9:1]}; // refill with idle level
				bitCnt <= bitCnt + 1'b1;
				if (bitCnt == 4'd9)
					txBusy <= 1'b0; // end of stop bit
			end
			else
				ovsCnt <= ovsCnt + 1'b1;
		end
	end

	assign serialTx = frame[0];

endmodule

/* hdl/bitStringCollector.sv */
`timescale 1ns/1ps

module bitStringCollector (
	input logic Uart_CLK,
	input logic Sys_RST,
	input uartPkg::rxCharT rxChar,
	input logic rxValid,
	input uartPkg::indexT frameLength,
	input logic holdIndex,
	output uartPkg::recvReportT recvReport
);
	import uartPkg::*;

	charT shiftReg;
	logic [2:0] bitCnt;
	logic isBit;
	logic newBit;

	// only clean '0' and '1' characters count
	assign isBit = rxValid && !rxChar.frameErr &&
		(rxChar.code == ASCII_ZERO || rxChar.code == ASCII_ONE);
	assign newBit = (rxChar.code == ASCII_ONE);

	always_ff @(posedge Uart_CLK or negedge Sys_RST) begin
		if (!Sys_RST) begin
			shiftReg <= '0;
			bitCnt <= '0;
			recvReport <= '0;
		end
		else begin
			if (isBit) begin
				shiftReg <= {shiftReg[6:0], newBit}; // msb first
				bitCnt <= bitCnt + 1'b1;
				if (bitCnt == 3'd7) begin
					recvReport.data <= {shiftReg[6:0], newBit};
					recvReport.index <= indexT'(frameLength + 5'd1);
				end
			end
			if (!holdIndex)
				recvReport.index <= '0; // overrides a frame completing now
		end
	end

endmodule

/* hdl/statusFormatter.sv */
`timescale 1ns/1ps

module statusFormatter (
	input uartPkg::statusT statusData,
	output uartPkg::statusLineT statusLine
);
	import uartPkg::*;

	logic [6:0] rest;
	logic [3:0] hundreds;
	logic [3:0] tens;

	// binary to decimal by repeated compare and subtract
	always_comb begin
		rest = statusData[6:0];
		hundreds = 4'd0;
		tens = 4'd0;
		if (rest >= 7'd100) begin
			hundreds = 4'd1;
			rest = rest - 7'd100;
		end
		for (int i = 0; i < 9; i++) begin
			if (rest >= 7'd10) begin
				tens = tens + 4'd1;
				rest = rest - 7'd10;
			end
		end
	end

	assign statusLine[0] = ASCII_ZERO + charT'(hundreds);
	assign statusLine[1] = ASCII_DOT;
	assign statusLine[2] = ASCII_ZERO + charT'(tens);
	assign statusLine[3] = ASCII_ZERO + charT'(rest[3:0]);
	assign statusLine[4] = ASCII_S;
	assign statusLine[5] = ASCII_COLON;
	assign statusLine[6] = charT'("O");
	assign statusLine[7] = statusData[7] ? charT'("n") : charT'("f");
	assign statusLine[8] = ASCII_CR;

endmodule

/* hdl/messageSequencer.sv */
`timescale 1ns/1ps

module messageSequencer (
	input logic Uart_CLK,
	input logic Sys_RST,
	input logic txRequest,
	input logic demoMode,
	input uartPkg::lightT light,
	input uartPkg::statusLineT statusLine,
	input logic txBusy,
	output uartPkg::charT txChar,
	output logic txWrite,
	output logic txIdle
);
	import uartPkg::*;

	seqStateE seqState;
	logic [3:0] charCnt;
	charT nextChar;
	logic lastChar;
	logic txFree;

	// busy rises one cycle late, so the own strobe also blocks
	assign txFree = !txBusy && !txWrite;

	always_comb begin
		if (seqState == seqLight) begin
			nextChar = LIGHT_NAMES[light][charCnt];
			lastChar = (charCnt == 4'(LIGHT_LEN - 1));
		end
		else begin
			nextChar = statusLine[charCnt];
			lastChar = (charCnt == 4'(STATUS_LEN - 1));
		end
	end

	always_ff @(posedge Uart_CLK or negedge Sys_RST) begin
		if (!Sys_RST) begin
			seqState <= seqIdle;
			charCnt <= '0;
			txChar <= '0;
			txWrite <= 1'b0;
			txIdle <= 1'b1;
		end
		else begin
			txWrite <= 1'b0;
			case (seqState)
				seqIdle: begin
					charCnt <= '0;
					if (txRequest) begin
						txIdle <= 1'b0;
						seqState <= demoMode ? seqLight : seqStatus;
					end
					else
						txIdle <= 1'b1;
				end
				seqStatus, seqLight: begin
					if (txFree) begin
						txChar <= nextChar;
						txWrite <= 1'b1;
						charCnt <= charCnt + 1'b1;
						if (lastChar)
							seqState <= seqDrain;
					end
				end
				seqDrain: begin
					if (txFree)
						seqState <= seqIdle; // last stop bit is out
				end
				default: seqState <= seqIdle;
			endcase
		end
	end

endmodule

/* hdl/uartTop.sv */
`timescale 1ns/1ps

module uartTop #(
	parameter int ovsRate = 16
) (
	input logic Uart_CLK,
	input logic Sys_RST,
	input logic serialRx,
	input uartPkg::lightT light,
	input uartPkg::statusT statusData,
	input uartPkg::indexT frameLength,
	input logic demoMode,
	input logic holdIndex,
	input logic txRequest,
	output logic serialTx,
	output logic txIdle,
	output uartPkg::indexT recvIndex,
	output uartPkg::charT recvData
);
	import uartPkg::*;

	rxCharT rxChar;
	logic rxValid;
	charT txChar;
	logic txWrite;
	logic txBusy;
	statusLineT statusLine;
	recvReportT recvReport;

	uartRx #(.ovsRate(ovsRate)) u_uartRx (.Uart_CLK, .Sys_RST, .serialRx, .rxChar, .rxValid);

	uartTx #(.ovsRate(ovsRate)) u_uartTx (.Uart_CLK, .Sys_RST, .txChar, .txWrite, .txBusy,
		.serialTx);

	bitStringCollector u_bitStringCollector (.Uart_CLK, .Sys_RST, .rxChar, .rxValid,
		.frameLength, .holdIndex, .recvReport);

	statusFormatter u_statusFormatter (.statusData, .statusLine);

	messageSequencer u_messageSequencer (.Uart_CLK, .Sys_RST, .txRequest, .demoMode, .light,
		.statusLine, .txBusy, .txChar, .txWrite, .txIdle);

	assign recvIndex = recvReport.index;
	assign recvData = recvReport.data;

endmodule

/* tests/uartTopTb.sv */
`timescale 1ns/1ps

module uartTopTb;
	import uartPkg::*;

	localparam int bitCycles = 16;
	localparam int clkPeriod = 20;
	// 15 status lines, 4 names, 16 + 9 received characters
	localparam int totalChars = 15 * STATUS_LEN + 4 * LIGHT_LEN + 16 + 9;
	localparam longint timeLimit = longint'(totalChars) * 10 * bitCycles * clkPeriod * 3 / 2;

	logic Uart_CLK;
	logic Sys_RST;
	logic serialRx;
	lightT light;
	statusT statusData;
	indexT frameLength;
	logic demoMode;
	logic holdIndex;
	logic txRequest;
	logic serialTx;
	logic txIdle;
	indexT recvIndex;
	charT recvData;

	charT gotQ[$]; // decoded from serialTx
	charT expQ[$];
	string curTest;
	statusT fixedStatus[5] = '{8'd0, 8'd5, 8'd99, 8'd127, 8'd128};

	uartTop #(.ovsRate(bitCycles)) u_dut (.Uart_CLK, .Sys_RST, .serialRx, .light, .statusData,
		.frameLength, .demoMode, .holdIndex, .txRequest, .serialTx, .txIdle, .recvIndex,
		.recvData);

	initial Uart_CLK = 1'b0;
	always #(clkPeriod / 2) Uart_CLK = ~Uart_CLK;

	task automatic reportFailure(input string msg);
		$display("%s", msg);
		$display("ERRORS FOUND");
		$fatal(1);
	endtask

	task automatic checkVal(input string testName, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("mismatch %s expected %0h actual %0h", testName, expected, actual);
			$display("ERRORS FOUND");
			$fatal(1);
		end
	endtask

	task automatic nextDrive();
		@(posedge Uart_CLK);
		#2;
	endtask

	function automatic string expectLine(input statusT status, input logic demo, input lightT sel);
		string name;
		int value;
		if (demo) begin
			case (sel)
				2'd0: name = "Off   ";
				2'd1: name = "White ";
				2'd2: name = "Sun   ";
				default: name = "Yellow";
			endcase
			return $sformatf("%s%c", name, 8'h0d);
		end
		value = status[6:0];
		return $sformatf("%0d.%0d%0ds:O%s%c", value / 100, (value / 10) % 10, value % 10,
			status[7] ? "n" : "f", 8'h0d);
	endfunction

	// call at posedge + 2 ns
	task automatic sendChar(input charT code, input logic stopBit);
		logic [9:0] frame;
		frame = {stopBit, code, 1'b0};
		for (int i = 0; i < 10; i++) begin
			serialRx = frame[i]; // lsb first after start
			repeat (bitCycles) @(posedge Uart_CLK);
			#2;
		end
		serialRx = 1'b1; // idle bit between characters
		repeat (bitCycles) @(posedge Uart_CLK);
		#2;
	endtask

	task automatic requestMessage(input string testName, input statusT status, input logic demo,
		input lightT sel);
		string line;
		line = expectLine(status, demo, sel);
		nextDrive();
		curTest = testName;
		for (int i = 0; i < line.len(); i++)
			expQ.push_back(line[i]);
		statusData = status;
		demoMode = demo;
		light = sel;
		txRequest = 1'b1;
		do
			@(negedge Uart_CLK);
		while (txIdle);
		nextDrive();
		txRequest = 1'b0;
		do
			@(negedge Uart_CLK);
		while (!txIdle);
		@(negedge Uart_CLK);
		checkVal({testName, " count"}, 0, expQ.size()); // all characters seen
	endtask

	task automatic receiveFrame(input string testName, input logic withBadChar,
		output charT expected);
		logic bitVal;
		expected = '0;
		nextDrive();
		frameLength = indexT'($urandom_range(0, 30));
		holdIndex = 1'b1;
		for (int i = 0; i < 8; i++) begin
			if (withBadChar) begin
				if (i == 4)
					sendChar(ASCII_ONE, 1'b0); // low stop bit, dropped
			end
			else
				sendChar(charT'(8'h61 + $urandom_range(0, 25)), 1'b1); // stray letter
			bitVal = 1'($urandom_range(0, 1));
			if (withBadChar && i == 4)
				bitVal = 1'b0; // a counted bad '1' would land here
			sendChar(bitVal ? ASCII_ONE : ASCII_ZERO, 1'b1);
			expected = {expected[6:0], bitVal};
		end
		checkVal({testName, " data"}, expected, recvData);
		checkVal({testName, " index"}, frameLength + 5'd1, recvIndex);
	endtask

	// serialTx decoder
	initial begin
		charT got;
		forever begin
			@(negedge serialTx);
			repeat (bitCycles / 2) @(negedge Uart_CLK);
			if (serialTx)
				reportFailure("start bit on serialTx ended too early");
			for (int i = 0; i < 8; i++) begin
				repeat (bitCycles) @(negedge Uart_CLK);
				got[i] = serialTx;
			end
			repeat (bitCycles) @(negedge Uart_CLK);
			if (!serialTx)
				reportFailure("stop bit on serialTx was low");
			else
				gotQ.push_back(got);
		end
	end

	initial begin
		charT got;
		forever begin
			wait (gotQ.size() != 0);
			got = gotQ.pop_front();
			if (expQ.size() == 0)
				reportFailure($sformatf("unexpected character %0h on serialTx", got));
			else
				checkVal(curTest, expQ.pop_front(), got);
		end
	end

	initial begin
		#(timeLimit);
		reportFailure("timed out before all tests finished");
	end

	initial begin
		statusT status;
		charT lastByte;
		void'($urandom(82088));
		Sys_RST = 1'b0;
		serialRx = 1'b1;
		light = '0;
		statusData = '0;
		frameLength = '0;
		demoMode = 1'b0;
		holdIndex = 1'b1;
		txRequest = 1'b0;
		curTest = "reset";
		repeat (4) @(posedge Uart_CLK);
		#2;
		Sys_RST = 1'b1;
		@(negedge Uart_CLK);
		checkVal("reset serialTx", 1, serialTx);
		checkVal("reset txIdle", 1, txIdle);
		checkVal("reset recvIndex", 0, recvIndex);
		checkVal("reset recvData", 0, recvData);

		foreach (fixedStatus[i])
			requestMessage($sformatf("status %0d", fixedStatus[i]), fixedStatus[i], 1'b0, 2'd0);
		repeat (10) begin
			status = statusT'($urandom_range(0, 255));
			requestMessage($sformatf("status %0d", status), status, 1'b0, 2'd0);
		end
		for (int i = 0; i < 4; i++)
			requestMessage($sformatf("light %0d", i), 8'h00, 1'b1, lightT'(i));

		receiveFrame("bit string", 1'b0, lastByte);
		receiveFrame("frame error", 1'b1, lastByte);

		nextDrive();
		holdIndex = 1'b0;
		repeat (2) @(negedge Uart_CLK);
		checkVal("index hold index", 0, recvIndex);
		checkVal("index hold data", lastByte, recvData);

		$display("NO ERRORS");
		$finish;
	end

endmodule

/* uartTop.f */
hdl/uartPkg.sv
hdl/uartRx.sv
hdl/uartTx.sv
hdl/bitStringCollector.sv
hdl/statusFormatter.sv
hdl/messageSequencer.sv
hdl/uartTop.sv
tests/uartTopTb.sv
